// File: src/soc_mem_settings.svh
`ifndef SOC_MEM_SETTINGS_SVH
`define SOC_MEM_SETTINGS_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// address map
`define SOC_CLINT_BASE 32'h0200_0000
// split point, anything at or above goes to the sram
`define SOC_SRAM_BASE 32'h0200_ffff

// sram depth in words
`define SOC_SRAM_WORDS 256

// beats per instruction burst, power of two for wrap
`define SOC_FETCH_BEATS 4

`endif

// File: src/soc_mem_pkg.sv
package soc_mem_pkg;

  // axi burst encoding
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_t;

endpackage

// File: src/axi_if.sv
`timescale 1ns/1ns
`include "soc_mem_settings.svh"

// read address and read data channels
interface axi_r_if;
  import soc_mem_pkg::*;

  logic arvalid;
  logic arready;
  logic [`SOC_ADDR_W-1:0] araddr;
  logic [7:0] arlen;
  axi_burst_t arburst;
  logic rvalid;
  logic rready;
  logic [`SOC_DATA_W-1:0] rdata;
  logic rlast;

  modport master (
    output arvalid, araddr, arlen, arburst, rready,
    input arready, rvalid, rdata, rlast
  );

  modport slave (
    input arvalid, araddr, arlen, arburst, rready,
    output arready, rvalid, rdata, rlast
  );
endinterface

// write address, write data and write response channels
interface axi_w_if;
  logic awvalid;
  logic awready;
  logic [`SOC_ADDR_W-1:0] awaddr;
  logic [7:0] awlen;
  logic wvalid;
  logic wready;
  logic [`SOC_DATA_W-1:0] wdata;
  logic [`SOC_DATA_W/8-1:0] wstrb;
  logic wlast;
  logic bvalid;
  logic bready;

  modport master (
    output awvalid, awaddr, awlen, wvalid, wdata, wstrb, wlast, bready,
    input awready, wready, bvalid
  );

  modport slave (
    input awvalid, awaddr, awlen, wvalid, wdata, wstrb, wlast, bready,
    output awready, wready, bvalid
  );
endinterface

// File: src/fetch_unit.sv
`timescale 1ns/1ns
`include "soc_mem_settings.svh"

module fetch_unit (
  input logic clock,
  input logic reset,
  input logic fetch_start,
  input logic [`SOC_ADDR_W-1:0] fetch_addr,
  output logic fetch_busy,
  output logic fetch_valid,
  output logic fetch_done,
  output logic [`SOC_DATA_W-1:0] fetch_data,
  axi_r_if.master bus
);
  import soc_mem_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA
  } fetch_state_t;

  fetch_state_t state;
  logic [`SOC_ADDR_W-1:0] pc_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
      bus.arvalid <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (fetch_start) begin
            bus.arvalid <= 1'b1;
            state <= ADDR;
          end
        end
        ADDR: begin
          if (bus.arready) begin
            bus.arvalid <= 1'b0;
            state <= DATA;
          end
        end
        DATA: begin
          if (bus.rvalid && bus.rlast) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // start address stays put until the last beat
  always_ff @(posedge clock) begin
    if (state == IDLE && fetch_start) begin
      pc_q <= fetch_addr;
    end
  end

  assign bus.araddr = pc_q;
  assign bus.arlen = 8'(`SOC_FETCH_BEATS - 1);
  assign bus.arburst = WRAP;
  assign bus.rready = 1'b1;

  // beats go straight out, rready is always high
  assign fetch_busy = state != IDLE;
  assign fetch_valid = bus.rvalid && (state == DATA);
  assign fetch_done = fetch_valid && bus.rlast;
  assign fetch_data = bus.rdata;

endmodule

// File: src/load_store_unit.sv
`timescale 1ns/1ns
`include "soc_mem_settings.svh"

module load_store_unit (
  input logic clock,
  input logic reset,
  input logic load,
  input logic store,
  input logic [`SOC_ADDR_W-1:0] addr,
  input logic [`SOC_DATA_W-1:0] wdata,
  input logic [3:0] wstrb,
  output logic lsu_busy,
  output logic lsu_done,
  output logic [`SOC_DATA_W-1:0] rdata,
  axi_r_if.master rd_bus,
  axi_w_if.master wr_bus
);
  import soc_mem_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    RD_ADDR,
    RD_DATA,
    WR_REQ,
    WR_RESP
  } lsu_state_t;

  lsu_state_t state;
  logic [`SOC_ADDR_W-1:0] addr_q;
  logic [`SOC_DATA_W-1:0] wdata_q;
  logic [3:0] wstrb_q;
  logic aw_done;
  logic w_done;

  // each write channel finishes on its own handshake
  assign aw_done = !wr_bus.awvalid || wr_bus.awready;
  assign w_done = !wr_bus.wvalid || wr_bus.wready;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
      lsu_done <= 1'b0;
      rd_bus.arvalid <= 1'b0;
      wr_bus.awvalid <= 1'b0;
      wr_bus.wvalid <= 1'b0;
    end else begin
      lsu_done <= 1'b0;
      case (state)
        IDLE: begin
          if (load) begin
            rd_bus.arvalid <= 1'b1;
            state <= RD_ADDR;
          end else if (store) begin
            wr_bus.awvalid <= 1'b1;
            wr_bus.wvalid <= 1'b1;
            state <= WR_REQ;
          end
        end
        RD_ADDR: begin
          if (rd_bus.arready) begin
            rd_bus.arvalid <= 1'b0;
            state <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (rd_bus.rvalid) begin
            lsu_done <= 1'b1;
            state <= IDLE;
          end
        end
        WR_REQ: begin
          if (wr_bus.awready) begin
            wr_bus.awvalid <= 1'b0;
          end
          if (wr_bus.wready) begin
            wr_bus.wvalid <= 1'b0;
          end
          if (aw_done && w_done) begin
            state <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (wr_bus.bvalid) begin
            lsu_done <= 1'b1;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == IDLE && (load || store)) begin
      addr_q <= addr;
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    // load data lands together with lsu_done
    if (state == RD_DATA && rd_bus.rvalid) begin
      rdata <= rd_bus.rdata;
    end
  end

  assign lsu_busy = state != IDLE;

  // single beat reads
  assign rd_bus.araddr = addr_q;
  assign rd_bus.arlen = 8'd0;
  assign rd_bus.arburst = INCR;
  assign rd_bus.rready = 1'b1;

  // single beat writes
  assign wr_bus.awaddr = addr_q;
  assign wr_bus.awlen = 8'd0;
  assign wr_bus.wdata = wdata_q;
  assign wr_bus.wstrb = wstrb_q;
  assign wr_bus.wlast = 1'b1;
  assign wr_bus.bready = 1'b1;

endmodule

// File: src/mem_interconnect.sv
`timescale 1ns/1ns
`include "soc_mem_settings.svh"

module mem_interconnect (
  input logic clock,
  input logic reset,
  axi_r_if.slave ifu_r,
  axi_r_if.slave lsu_r,
  axi_w_if.slave lsu_w,
  axi_r_if.master clint_r,
  axi_r_if.master sram_r,
  axi_w_if.master clint_w,
  axi_w_if.master sram_w
);
  import soc_mem_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    IFUR,
    LSUR
  } xbar_owner_t;

  xbar_owner_t owner;
  xbar_owner_t owner_next;
  logic ifu_end;
  logic lsu_end;

  // muxed read request from the owner
  logic m_arvalid;
  logic m_rready;
  logic [`SOC_ADDR_W-1:0] m_araddr;
  logic [7:0] m_arlen;
  axi_burst_t m_arburst;

  // response from the decoded slave
  logic s_arready;
  logic s_rvalid;
  logic [`SOC_DATA_W-1:0] s_rdata;
  logic s_rlast;

  logic rd_sram;
  logic wr_sram;

  assign ifu_end = ifu_r.rready && ifu_r.rvalid && ifu_r.rlast;
  assign lsu_end = lsu_r.rready && lsu_r.rvalid && lsu_r.rlast;

  always_ff @(posedge clock) begin
    if (reset) begin
      owner <= IDLE;
    end else begin
      owner <= owner_next;
    end
  end

  // fetch first, owner kept until its last beat
  always_comb begin
    case (owner)
      IDLE: begin
        if (ifu_r.arvalid) begin
          owner_next = IFUR;
        end else if (lsu_r.arvalid) begin
          owner_next = LSUR;
        end else begin
          owner_next = IDLE;
        end
      end
      IFUR: begin
        if (ifu_end) begin
          owner_next = lsu_r.arvalid ? LSUR : IDLE;
        end else begin
          owner_next = IFUR;
        end
      end
      LSUR: begin
        if (lsu_end) begin
          owner_next = ifu_r.arvalid ? IFUR : IDLE;
        end else begin
          owner_next = LSUR;
        end
      end
      default: owner_next = IDLE;
    endcase
  end

  always_comb begin
    case (owner)
      IFUR: begin
        m_arvalid = ifu_r.arvalid;
        m_rready = ifu_r.rready;
      end
      LSUR: begin
        m_arvalid = lsu_r.arvalid;
        m_rready = lsu_r.rready;
      end
      default: begin
        m_arvalid = 1'b0;
        m_rready = 1'b0;
      end
    endcase
  end

  assign m_araddr = (owner == LSUR) ? lsu_r.araddr : ifu_r.araddr;
  assign m_arlen = (owner == LSUR) ? lsu_r.arlen : ifu_r.arlen;
  assign m_arburst = (owner == LSUR) ? lsu_r.arburst : ifu_r.arburst;

  // only the owner sees arready and rvalid
  assign ifu_r.arready = (owner == IFUR) && s_arready;
  assign lsu_r.arready = (owner == LSUR) && s_arready;
  assign ifu_r.rvalid = (owner == IFUR) && s_rvalid;
  assign lsu_r.rvalid = (owner == LSUR) && s_rvalid;
  assign ifu_r.rdata = s_rdata;
  assign lsu_r.rdata = s_rdata;
  assign ifu_r.rlast = s_rlast;
  assign lsu_r.rlast = s_rlast;

  // read decode on the held address
  assign rd_sram = m_araddr >= `SOC_SRAM_BASE;

  assign sram_r.arvalid = rd_sram && m_arvalid;
  assign clint_r.arvalid = !rd_sram && m_arvalid;
  assign sram_r.araddr = m_araddr;
  assign clint_r.araddr = m_araddr;
  assign sram_r.arlen = m_arlen;
  assign clint_r.arlen = m_arlen;
  assign sram_r.arburst = m_arburst;
  assign clint_r.arburst = m_arburst;
  assign sram_r.rready = rd_sram && m_rready;
  assign clint_r.rready = !rd_sram && m_rready;

  assign s_arready = rd_sram ? sram_r.arready : clint_r.arready;
  assign s_rvalid = rd_sram ? sram_r.rvalid : clint_r.rvalid;
  assign s_rdata = rd_sram ? sram_r.rdata : clint_r.rdata;
  assign s_rlast = rd_sram ? sram_r.rlast : clint_r.rlast;

  // writes come only from the lsu, decode without arbitration
  assign wr_sram = lsu_w.awaddr >= `SOC_SRAM_BASE;

  assign sram_w.awvalid = wr_sram && lsu_w.awvalid;
  assign clint_w.awvalid = !wr_sram && lsu_w.awvalid;
  assign sram_w.awaddr = lsu_w.awaddr;
  assign clint_w.awaddr = lsu_w.awaddr;
  assign sram_w.awlen = lsu_w.awlen;
  assign clint_w.awlen = lsu_w.awlen;
  assign sram_w.wvalid = wr_sram && lsu_w.wvalid;
  assign clint_w.wvalid = !wr_sram && lsu_w.wvalid;
  assign sram_w.wdata = lsu_w.wdata;
  assign clint_w.wdata = lsu_w.wdata;
  assign sram_w.wstrb = lsu_w.wstrb;
  assign clint_w.wstrb = lsu_w.wstrb;
  assign sram_w.wlast = lsu_w.wlast;
  assign clint_w.wlast = lsu_w.wlast;
  assign sram_w.bready = wr_sram && lsu_w.bready;
  assign clint_w.bready = !wr_sram && lsu_w.bready;

  assign lsu_w.awready = wr_sram ? sram_w.awready : clint_w.awready;
  assign lsu_w.wready = wr_sram ? sram_w.wready : clint_w.wready;
  assign lsu_w.bvalid = wr_sram ? sram_w.bvalid : clint_w.bvalid;

endmodule

// File: src/clint.sv
`timescale 1ns/1ns
`include "soc_mem_settings.svh"

module clint (
  input logic clock,
  input logic reset,
  axi_r_if.slave rd,
  axi_w_if.slave wr,
  output logic timer_irq
);
  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic [`SOC_ADDR_W-1:0] r_rel;
  logic [`SOC_ADDR_W-1:0] w_rel;
  logic [`SOC_DATA_W-1:0] r_word;
  logic w_accept;

  // offsets inside the clint region
  assign r_rel = rd.araddr - `SOC_CLINT_BASE;
  assign w_rel = wr.awaddr - `SOC_CLINT_BASE;

  always_comb begin
    case (r_rel[15:0])
      16'h4000: r_word = mtimecmp[31:0];
      16'h4004: r_word = mtimecmp[63:32];
      16'hbff8: r_word = mtime[31:0];
      16'hbffc: r_word = mtime[63:32];
      default: r_word = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
      timer_irq <= 1'b0;
    end else begin
      mtime <= mtime + 64'd1;
      timer_irq <= mtime >= mtimecmp;
    end
  end

  // arready one cycle after arvalid, beat held until taken
  always_ff @(posedge clock) begin
    if (reset) begin
      rd.arready <= 1'b0;
      rd.rvalid <= 1'b0;
    end else begin
      if (rd.arvalid && rd.arready) begin
        rd.arready <= 1'b0;
        rd.rvalid <= 1'b1;
      end else if (rd.arvalid && !rd.rvalid) begin
        rd.arready <= 1'b1;
      end
      if (rd.rvalid && rd.rready) begin
        rd.rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rd.arvalid && rd.arready) begin
      rd.rdata <= r_word;
    end
  end

  assign rd.rlast = 1'b1;

  // aw and w taken together, only mtimecmp is writable
  always_ff @(posedge clock) begin
    if (reset) begin
      w_accept <= 1'b0;
      wr.bvalid <= 1'b0;
      mtimecmp <= '1;
    end else begin
      if (wr.awvalid && w_accept) begin
        w_accept <= 1'b0;
        wr.bvalid <= 1'b1;
        for (int b = 0; b < 4; b++) begin
          if (wr.wstrb[b] && w_rel[15:0] == 16'h4000) begin
            mtimecmp[8*b +: 8] <= wr.wdata[8*b +: 8];
          end else if (wr.wstrb[b] && w_rel[15:0] == 16'h4004) begin
            mtimecmp[32+8*b +: 8] <= wr.wdata[8*b +: 8];
          end
        end
      end else if (wr.awvalid && wr.wvalid && !w_accept && !wr.bvalid) begin
        w_accept <= 1'b1;
      end
      if (wr.bvalid && wr.bready) begin
        wr.bvalid <= 1'b0;
      end
    end
  end

  assign wr.awready = w_accept;
  assign wr.wready = w_accept;

endmodule

// File: src/sram_slave.sv
`timescale 1ns/1ns
`include "soc_mem_settings.svh"

module sram_slave (
  input logic clock,
  input logic reset,
  axi_r_if.slave rd,
  axi_w_if.slave wr
);
  import soc_mem_pkg::*;

  localparam int IDX_W = $clog2(`SOC_SRAM_WORDS);

  logic [`SOC_DATA_W-1:0] mem [`SOC_SRAM_WORDS];
  logic rd_busy;
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] next_idx;
  logic [IDX_W-1:0] wrap_mask;
  logic [7:0] beats_left;
  axi_burst_t rd_burst;
  logic w_accept;

  // address stepping between beats
  always_comb begin
    case (rd_burst)
      INCR: next_idx = rd_idx + IDX_W'(1);
      WRAP: next_idx = (rd_idx & ~wrap_mask) | ((rd_idx + IDX_W'(1)) & wrap_mask);
      default: next_idx = rd_idx;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd.arready <= 1'b0;
      rd.rvalid <= 1'b0;
      rd_busy <= 1'b0;
    end else begin
      if (rd.arvalid && rd.arready) begin
        rd.arready <= 1'b0;
        rd_busy <= 1'b1;
      end else if (rd.arvalid && !rd_busy) begin
        rd.arready <= 1'b1;
      end
      if (rd_busy && !rd.rvalid) begin
        rd.rvalid <= 1'b1;
      end else if (rd.rvalid && rd.rready && rd.rlast) begin
        rd.rvalid <= 1'b0;
        rd_busy <= 1'b0;
      end
    end
  end

  // burst bookkeeping and read data with one beat per cycle while rready
  always_ff @(posedge clock) begin
    if (rd.arvalid && rd.arready) begin
      rd_idx <= rd.araddr[IDX_W+1:2];
      wrap_mask <= IDX_W'(rd.arlen);
      beats_left <= rd.arlen;
      rd_burst <= rd.arburst;
    end else if (rd_busy && !rd.rvalid) begin
      rd.rdata <= mem[rd_idx];
    end else if (rd.rvalid && rd.rready && !rd.rlast) begin
      rd_idx <= next_idx;
      beats_left <= beats_left - 8'd1;
      rd.rdata <= mem[next_idx];
    end
  end

  assign rd.rlast = rd.rvalid && (beats_left == 8'd0);

  // bvalid follows the write accept edge
  always_ff @(posedge clock) begin
    if (reset) begin
      w_accept <= 1'b0;
      wr.bvalid <= 1'b0;
    end else begin
      if (wr.awvalid && w_accept) begin
        w_accept <= 1'b0;
        wr.bvalid <= 1'b1;
      end else if (wr.awvalid && wr.wvalid && !w_accept && !wr.bvalid) begin
        w_accept <= 1'b1;
      end
      if (wr.bvalid && wr.bready) begin
        wr.bvalid <= 1'b0;
      end
    end
  end

  assign wr.awready = w_accept;
  assign wr.wready = w_accept;

  // clear walk on reset and byte lanes on write
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `SOC_SRAM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr.awvalid && w_accept) begin
      for (int b = 0; b < `SOC_DATA_W/8; b++) begin
        if (wr.wstrb[b]) begin
          mem[wr.awaddr[IDX_W+1:2]][8*b +: 8] <= wr.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: src/soc_mem_top.sv
`timescale 1ns/1ns
`include "soc_mem_settings.svh"

module soc_mem_top (
  input logic clock,
  input logic reset,
  input logic fetch_start,
  input logic [`SOC_ADDR_W-1:0] fetch_addr,
  output logic fetch_busy,
  output logic fetch_valid,
  output logic fetch_done,
  output logic [`SOC_DATA_W-1:0] fetch_data,
  input logic load,
  input logic store,
  input logic [`SOC_ADDR_W-1:0] addr,
  input logic [`SOC_DATA_W-1:0] wdata,
  input logic [3:0] wstrb,
  output logic lsu_busy,
  output logic lsu_done,
  output logic [`SOC_DATA_W-1:0] rdata,
  output logic timer_irq
);
  // master side buses
  axi_r_if ifu_r ();
  axi_r_if lsu_r ();
  axi_w_if lsu_w ();

  // slave side buses
  axi_r_if clint_r ();
  axi_w_if clint_w ();
  axi_r_if sram_r ();
  axi_w_if sram_w ();

  fetch_unit u_fetch (
    .clock(clock),
    .reset(reset),
    .fetch_start(fetch_start),
    .fetch_addr(fetch_addr),
    .fetch_busy(fetch_busy),
    .fetch_valid(fetch_valid),
    .fetch_done(fetch_done),
    .fetch_data(fetch_data),
    .bus(ifu_r)
  );

  load_store_unit u_lsu (
    .clock(clock),
    .reset(reset),
    .load(load),
    .store(store),
    .addr(addr),
    .wdata(wdata),
    .wstrb(wstrb),
    .lsu_busy(lsu_busy),
    .lsu_done(lsu_done),
    .rdata(rdata),
    .rd_bus(lsu_r),
    .wr_bus(lsu_w)
  );

  mem_interconnect u_xbar (
    .clock(clock),
    .reset(reset),
    .ifu_r(ifu_r),
    .lsu_r(lsu_r),
    .lsu_w(lsu_w),
    .clint_r(clint_r),
    .sram_r(sram_r),
    .clint_w(clint_w),
    .sram_w(sram_w)
  );

  clint u_clint (
    .clock(clock),
    .reset(reset),
    .rd(clint_r),
    .wr(clint_w),
    .timer_irq(timer_irq)
  );

  sram_slave u_sram (
    .clock(clock),
    .reset(reset),
    .rd(sram_r),
    .wr(sram_w)
  );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clock,
  output logic reset
);
  // 10 ns period
  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // reset held over the first 10 rising edges
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
  end
endmodule

// File: test/tb_soc_mem.sv
`timescale 1ns/1ns
`include "soc_mem_settings.svh"

module tb_soc_mem;
  localparam int TIMEOUT = 60;
  localparam int WORDS = `SOC_SRAM_WORDS;
  localparam int IDX_W = $clog2(WORDS);
  localparam int BEATS = `SOC_FETCH_BEATS;
  // first word aligned address at or above the split point
  localparam logic [31:0] SRAM_LO = (`SOC_SRAM_BASE + 32'd3) & ~32'd3;
  localparam logic [31:0] CMP_LO = `SOC_CLINT_BASE + 32'h4000;
  localparam logic [31:0] CMP_HI = `SOC_CLINT_BASE + 32'h4004;
  localparam logic [31:0] TIME_LO = `SOC_CLINT_BASE + 32'hbff8;

  logic clock;
  logic reset;
  logic fetch_start;
  logic [`SOC_ADDR_W-1:0] fetch_addr;
  logic fetch_busy;
  logic fetch_valid;
  logic fetch_done;
  logic [`SOC_DATA_W-1:0] fetch_data;
  logic load;
  logic store;
  logic [`SOC_ADDR_W-1:0] addr;
  logic [`SOC_DATA_W-1:0] wdata;
  logic [3:0] wstrb;
  logic lsu_busy;
  logic lsu_done;
  logic [`SOC_DATA_W-1:0] rdata;
  logic timer_irq;

  // reference state
  logic [31:0] mem_model [WORDS];
  logic [63:0] cmp_model;
  logic [31:0] rng;
  logic [IDX_W-1:0] written [$];
  int checks;
  int errors;

  tb_clock_gen u_clock_gen (
    .clock(clock),
    .reset(reset)
  );

  soc_mem_top uut (
    .clock(clock),
    .reset(reset),
    .fetch_start(fetch_start),
    .fetch_addr(fetch_addr),
    .fetch_busy(fetch_busy),
    .fetch_valid(fetch_valid),
    .fetch_done(fetch_done),
    .fetch_data(fetch_data),
    .load(load),
    .store(store),
    .addr(addr),
    .wdata(wdata),
    .wstrb(wstrb),
    .lsu_busy(lsu_busy),
    .lsu_done(lsu_done),
    .rdata(rdata),
    .timer_irq(timer_irq)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_rand(output logic [31:0] value);
    rng = xorshift32(rng);
    value = rng;
  endtask

  // strobe bit n keeps byte n of the new word
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] d,
                                              input logic [3:0] s);
    logic [31:0] mask;
    mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    return (old & ~mask) | (d & mask);
  endfunction

  function automatic logic [31:0] sram_addr(input logic [IDX_W-1:0] idx);
    return SRAM_LO + (32'(idx) << 2);
  endfunction

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("check failed at %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t ns: %s", $time, what);
    errors++;
  endtask

  task automatic report_test(input string name, input int chk0, input int err0);
    $display("test %s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
  endtask

  // one load or store that waits for the lsu_done pulse
  task automatic lsu_access(input logic is_store, input logic [31:0] a, input logic [31:0] d,
                            input logic [3:0] s, output logic [31:0] got);
    int n;
    @(posedge clock);
    load <= !is_store;
    store <= is_store;
    addr <= a;
    wdata <= d;
    wstrb <= s;
    @(posedge clock);
    load <= 1'b0;
    store <= 1'b0;
    n = 0;
    @(negedge clock);
    check_eq("lsu_busy", 32'd1, {31'd0, lsu_busy});
    while (!lsu_done && n < TIMEOUT) begin
      @(negedge clock);
      n++;
    end
    if (!lsu_done) begin
      report_timeout(is_store ? "store never finished" : "load never finished");
    end
    got = rdata;
  endtask

  // instruction burst with an optional load strobed in the same cycle
  task automatic fetch_and_load(input logic [IDX_W-1:0] start, input logic with_load,
                                input logic [IDX_W-1:0] lidx);
    int beats;
    int cyc;
    int first_fetch;
    int done_at;
    logic fetch_end;
    logic load_end;
    logic [IDX_W-1:0] widx;
    @(posedge clock);
    fetch_start <= 1'b1;
    fetch_addr <= sram_addr(start);
    if (with_load) begin
      load <= 1'b1;
      addr <= sram_addr(lidx);
    end
    @(posedge clock);
    fetch_start <= 1'b0;
    load <= 1'b0;
    beats = 0;
    cyc = 0;
    first_fetch = -1;
    done_at = -1;
    fetch_end = 1'b0;
    load_end = !with_load;
    while (!(fetch_end && load_end) && cyc < TIMEOUT) begin
      @(negedge clock);
      cyc++;
      if (cyc == 1) begin
        check_eq("fetch_busy", 32'd1, {31'd0, fetch_busy});
      end
      if (fetch_valid) begin
        if (first_fetch < 0) begin
          first_fetch = cyc;
        end
        // wrap window aligned to the burst length
        widx = IDX_W'((int'(start) / BEATS) * BEATS + (int'(start) % BEATS + beats) % BEATS);
        check_eq("fetch_data", mem_model[widx], fetch_data);
        check_eq("fetch_done", {31'd0, beats == BEATS - 1}, {31'd0, fetch_done});
        beats++;
        fetch_end = fetch_done;
      end
      if (with_load && lsu_done) begin
        done_at = cyc;
        load_end = 1'b1;
        check_eq("rdata", mem_model[lidx], rdata);
      end
    end
    if (!(fetch_end && load_end)) begin
      report_timeout("fetch burst or load did not finish");
    end
    check_eq("fetch beat count", BEATS, beats);
    if (with_load) begin
      check_true(first_fetch >= 0 && first_fetch < done_at,
                 "first fetch word did not arrive before lsu_done");
    end
  endtask

  initial begin
    int chk0;
    int err0;
    int n;
    logic [IDX_W-1:0] idx;
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] got;
    logic [31:0] first_time;
    logic half;

    fetch_start = 1'b0;
    fetch_addr = '0;
    load = 1'b0;
    store = 1'b0;
    addr = '0;
    wdata = '0;
    wstrb = '0;
    rng = 32'd41140;
    checks = 0;
    errors = 0;
    mem_model = '{default: '0};
    cmp_model = '1;

    n = 0;
    @(posedge clock);
    while (reset && n < 40) begin
      @(posedge clock);
      n++;
    end
    if (reset) begin
      report_timeout("reset never released");
    end
    @(negedge clock);

    chk0 = checks;
    err0 = errors;
    check_eq("fetch_busy", 32'd0, {31'd0, fetch_busy});
    check_eq("fetch_valid", 32'd0, {31'd0, fetch_valid});
    check_eq("fetch_done", 32'd0, {31'd0, fetch_done});
    check_eq("lsu_busy", 32'd0, {31'd0, lsu_busy});
    check_eq("lsu_done", 32'd0, {31'd0, lsu_done});
    check_eq("timer_irq", 32'd0, {31'd0, timer_irq});
    report_test("reset", chk0, err0);

    // strobed stores each followed by two loads of written words
    chk0 = checks;
    err0 = errors;
    for (int i = 0; i < 40; i++) begin
      next_rand(r);
      next_rand(d);
      idx = r[IDX_W-1:0];
      lsu_access(1'b1, sram_addr(idx), d, r[11:8], got);
      mem_model[idx] = merge_bytes(mem_model[idx], d, r[11:8]);
      written.push_back(idx);
      for (int k = 0; k < 2; k++) begin
        next_rand(r);
        idx = written[r % written.size()];
        lsu_access(1'b0, sram_addr(idx), 32'd0, 4'd0, got);
        check_eq("rdata", mem_model[idx], got);
      end
    end
    report_test("store_load", chk0, err0);

    chk0 = checks;
    err0 = errors;
    for (int i = 0; i < 12; i++) begin
      next_rand(r);
      fetch_and_load(r[IDX_W-1:0], 1'b0, '0);
    end
    report_test("fetch_wrap", chk0, err0);

    // fetch and load strobed together so fetch must win the read path
    chk0 = checks;
    err0 = errors;
    for (int i = 0; i < 20; i++) begin
      next_rand(r);
      next_rand(d);
      fetch_and_load(r[IDX_W-1:0], 1'b1, written[d % written.size()]);
    end
    report_test("contention", chk0, err0);

    chk0 = checks;
    err0 = errors;
    for (int i = 0; i < 8; i++) begin
      next_rand(r);
      next_rand(d);
      half = r[0];
      lsu_access(1'b1, half ? CMP_HI : CMP_LO, d, r[7:4], got);
      if (half) begin
        cmp_model[63:32] = merge_bytes(cmp_model[63:32], d, r[7:4]);
      end else begin
        cmp_model[31:0] = merge_bytes(cmp_model[31:0], d, r[7:4]);
      end
      lsu_access(1'b0, CMP_LO, 32'd0, 4'd0, got);
      check_eq("mtimecmp low", cmp_model[31:0], got);
      lsu_access(1'b0, CMP_HI, 32'd0, 4'd0, got);
      check_eq("mtimecmp high", cmp_model[63:32], got);
    end
    // clint writes must not reach the sram
    foreach (written[j]) begin
      lsu_access(1'b0, sram_addr(written[j]), 32'd0, 4'd0, got);
      check_eq("rdata", mem_model[written[j]], got);
    end
    // sram words that share index bits with the mtimecmp offsets
    for (int j = 0; j < 2; j++) begin
      idx = j ? CMP_HI[IDX_W+1:2] : CMP_LO[IDX_W+1:2];
      lsu_access(1'b0, sram_addr(idx), 32'd0, 4'd0, got);
      check_eq("rdata", mem_model[idx], got);
    end
    report_test("clint_decode", chk0, err0);

    chk0 = checks;
    err0 = errors;
    lsu_access(1'b0, TIME_LO, 32'd0, 4'd0, first_time);
    lsu_access(1'b0, TIME_LO, 32'd0, 4'd0, got);
    check_true(got > first_time, "mtime low did not increase between two loads");
    lsu_access(1'b1, CMP_LO, 32'd0, 4'hf, got);
    lsu_access(1'b1, CMP_HI, 32'd0, 4'hf, got);
    n = 0;
    while (!timer_irq && n < 3) begin
      @(negedge clock);
      n++;
    end
    check_true(timer_irq, "timer_irq not high within 3 cycles after mtimecmp was cleared");
    lsu_access(1'b1, CMP_LO, 32'hffff_ffff, 4'hf, got);
    lsu_access(1'b1, CMP_HI, 32'hffff_ffff, 4'hf, got);
    n = 0;
    while (timer_irq && n < 3) begin
      @(negedge clock);
      n++;
    end
    check_true(!timer_irq, "timer_irq not low within 3 cycles after mtimecmp was set");
    report_test("timer", chk0, err0);

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end
endmodule

// File: filelist.f
+incdir+src
src/soc_mem_pkg.sv
src/axi_if.sv
src/fetch_unit.sv
src/load_store_unit.sv
src/mem_interconnect.sv
src/clint.sv
src/sram_slave.sv
src/soc_mem_top.sv
test/tb_clock_gen.sv
test/tb_soc_mem.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_soc_mem
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_MSG ?= TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
